//--- verilog/smc_lite_pkg.sv
/*
 * Static memory controller shared definitions
 * Widths, size codes, access state enum, request and EMI structs
 * Also holds the per-access low address bit rule used by two blocks
 */

package smc_lite_pkg;

   typedef logic [31:0] addr_t;   // Host address
   typedef logic [31:0] data_t;   // Data word
   typedef logic [3:0]  be_t;     // Active low byte enables
   typedef logic [1:0]  size_t;   // Transfer or bus size code
   typedef logic [1:0]  acc_cnt_t; // Remaining accesses

   // Size codes --------------------
   localparam size_t XSIZ_8  = 2'd0;
   localparam size_t XSIZ_16 = 2'd1;
   localparam size_t XSIZ_32 = 2'd2;
   localparam size_t BSIZ_8  = 2'd0;
   localparam size_t BSIZ_16 = 2'd1;
   localparam size_t BSIZ_32 = 2'd2;

   typedef enum logic [1:0] {
      SMC_IDLE,
      SMC_RW,
      SMC_DONE
   } smc_state_e;

   typedef struct packed {
      addr_t addr;
      size_t xfer_size;
      logic  write;
      data_t wdata;
   } smc_req_t;

   typedef struct packed {
      logic  n_cs;
      be_t   n_be;
      logic  n_we;
      logic  n_oe;
      data_t wdata;
   } smc_emi_t;

   // Low address bits of the current access
   // Little-endian, highest part of the transfer goes out first
   function automatic logic [1:0] acc_low(size_t xfer, size_t bus, logic [1:0] a_lo,
                                          logic first, acc_cnt_t cnt);
      logic [1:0] step;
      step = cnt - 2'd1;   // Index of this access from the bottom
      acc_low = a_lo;
      case ({xfer, bus})
         {XSIZ_32, BSIZ_32}: acc_low = 2'b00;
         {XSIZ_32, BSIZ_16}: acc_low = first ? 2'b10 : {step[0], 1'b0};
         {XSIZ_32, BSIZ_8}:  acc_low = first ? 2'b11 : step;
         {XSIZ_16, BSIZ_8}:  acc_low = first ? {a_lo[1], 1'b1} : {a_lo[1], step[0]};
         {XSIZ_16, BSIZ_16}: acc_low = {a_lo[1], 1'b0};
         {XSIZ_16, BSIZ_32}: acc_low = {a_lo[1], 1'b0};
         default:            acc_low = a_lo;   // Bytes go out as addressed
      endcase
   endfunction

endpackage

//--- verilog/smc_host_if.sv
/*
 * Host side of the memory controller
 * Four-phase req/ack slave, captures the request and starts the access
 * Returns the assembled read word with ack, held until req falls
 */

`timescale 1ns/1ps

module smc_host_if (
   input  logic                   sys_clk12,
   input  logic                   n_sys_reset12,
   input  logic                   req,          // Host request
   output logic                   ack,          // Transfer complete
   input  smc_lite_pkg::smc_req_t req_in,       // Held stable with req
   output smc_lite_pkg::data_t    rdata,        // Valid while ack high
   output smc_lite_pkg::smc_req_t cur_req,      // Captured request
   output logic                   valid_access, // Start of new transfer
   input  logic                   smc_done,     // Last access cycle
   input  smc_lite_pkg::data_t    rd_word       // Assembled read data
);

   // Handshake states
   localparam logic [1:0] HS_IDLE  = 2'd0;
   localparam logic [1:0] HS_BUSY  = 2'd1;
   localparam logic [1:0] HS_ACKED = 2'd2;

   logic [1:0] hs_state;
   logic       start;

   assign start = (hs_state == HS_IDLE) && req;   // New request seen

   // Handshake control --------------------
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
      begin
         hs_state     <= HS_IDLE;
         ack          <= 1'b0;
         valid_access <= 1'b0;
      end
      else
      begin
         valid_access <= start;   // One cycle pulse
         case (hs_state)
            HS_IDLE:
               if (req)
                  hs_state <= HS_BUSY;
            HS_BUSY:
               if (smc_done)
               begin
                  ack      <= 1'b1;
                  hs_state <= HS_ACKED;
               end
            HS_ACKED:
               if (!req)
               begin
                  ack      <= 1'b0;   // Falls one clock after req
                  hs_state <= HS_IDLE;
               end
            default:
               hs_state <= HS_IDLE;
         endcase
      end
   end

   // Request and response payload --------------------
   always_ff @(posedge sys_clk12)
   begin
      if (start)
         cur_req <= req_in;
      if ((hs_state == HS_BUSY) && smc_done)
         rdata <= rd_word;   // All lanes in by now
   end

endmodule

//--- verilog/smc_access_ctrl.sv
/*
 * Access sequencer
 * Splits a transfer into 1, 2 or 4 bus accesses
 * Drives the next access state, the remaining access count and done
 */

`timescale 1ns/1ps

module smc_access_ctrl (
   input  logic                     sys_clk12,
   input  logic                     n_sys_reset12,
   input  logic                     valid_access,  // Start of transfer
   input  smc_lite_pkg::size_t      xfer_size,     // Host transfer size
   input  smc_lite_pkg::size_t      bus_size,      // External bus width
   output smc_lite_pkg::smc_state_e smc_nextstate, // Next access state
   output smc_lite_pkg::acc_cnt_t   r_num_access,  // Accesses still to go
   output logic                     smc_done       // Last EMI access cycle
);

   smc_lite_pkg::smc_state_e r_state;
   smc_lite_pkg::acc_cnt_t   num_load;   // N-1 for this transfer

   // Access count from the size pair --------------------
   always_comb
   begin
      num_load = 2'd0;   // One access, also for invalid codes
      case ({xfer_size, bus_size})
         {smc_lite_pkg::XSIZ_16, smc_lite_pkg::BSIZ_8}:  num_load = 2'd1;
         {smc_lite_pkg::XSIZ_32, smc_lite_pkg::BSIZ_16}: num_load = 2'd1;
         {smc_lite_pkg::XSIZ_32, smc_lite_pkg::BSIZ_8}:  num_load = 2'd3;
         default:                                        num_load = 2'd0;
      endcase
   end

   // Next state --------------------
   always_comb
   begin
      smc_nextstate = r_state;
      case (r_state)
         smc_lite_pkg::SMC_IDLE:
            if (valid_access)
               smc_nextstate = smc_lite_pkg::SMC_RW;
         smc_lite_pkg::SMC_RW:
            if (r_num_access != 2'd0)
               smc_nextstate = smc_lite_pkg::SMC_RW;   // More to go
            else
               smc_nextstate = smc_lite_pkg::SMC_DONE;
         smc_lite_pkg::SMC_DONE:
            if (valid_access)
               smc_nextstate = smc_lite_pkg::SMC_RW;
            else
               smc_nextstate = smc_lite_pkg::SMC_IDLE;
         default:
            smc_nextstate = smc_lite_pkg::SMC_IDLE;
      endcase
   end

   // Last strobe cycle on the EMI is the cycle that enters DONE
   assign smc_done = (smc_nextstate == smc_lite_pkg::SMC_DONE);

   // State and down-counter --------------------
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
      begin
         r_state      <= smc_lite_pkg::SMC_IDLE;
         r_num_access <= 2'd0;
      end
      else
      begin
         r_state <= smc_nextstate;
         if (valid_access)
            r_num_access <= num_load;   // Load on start
         else if ((r_state == smc_lite_pkg::SMC_RW) && (r_num_access != 2'd0))
            r_num_access <= r_num_access - 2'd1;
      end
   end

endmodule

//--- verilog/smc_addr_gen.sv
/*
 * External address and strobe generator
 * Registers the EMI address, chip select and byte enables per access
 * Low address bits step down through the parts of a split transfer
 */

`timescale 1ns/1ps

module smc_addr_gen #(
   parameter int ADDR_WIDTH = 24   // External address port width
) (
   input  logic                     sys_clk12,
   input  logic                     n_sys_reset12,
   input  logic                     valid_access,  // Start of transfer
   input  smc_lite_pkg::smc_req_t   cur_req,       // Captured request
   input  smc_lite_pkg::size_t      bus_size,      // External bus width
   input  smc_lite_pkg::smc_state_e smc_nextstate, // Next access state
   input  smc_lite_pkg::acc_cnt_t   r_num_access,  // Accesses still to go
   output logic [ADDR_WIDTH-1:0]    emi_addr,      // EMI address
   output logic                     n_cs,          // EMI chip select
   output smc_lite_pkg::be_t        n_be           // EMI byte enables
);

   logic [1:0]        r_addr;   // Stored low host address bits
   logic [1:0]        v_addr;   // Validated low address bits
   logic [1:0]        acc_lo;   // Low bits of this access
   logic              acc_rw;   // Access strobes next cycle
   smc_lite_pkg::be_t be_dec;   // Decoded enables, unregistered

   assign acc_rw = (smc_nextstate == smc_lite_pkg::SMC_RW);

   // Live bits on the start cycle, stored ones afterwards
   assign v_addr = valid_access ? cur_req.addr[1:0] : r_addr;

   assign acc_lo = smc_lite_pkg::acc_low(cur_req.xfer_size, bus_size, v_addr,
                                         valid_access, r_num_access);

   // Low address store --------------------
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
         r_addr <= 2'd0;
      else if (valid_access)
         r_addr <= cur_req.addr[1:0];
   end

   // External address --------------------
   always_ff @(posedge sys_clk12)
   begin
      if (acc_rw)
         emi_addr <= {cur_req.addr[ADDR_WIDTH-1:2], acc_lo};   // Upper bits truncated
   end

   // Byte enable decode --------------------
   always_comb
   begin
      be_dec = 4'b1111;   // Invalid decode, nothing enabled
      case ({cur_req.xfer_size, bus_size})
         {smc_lite_pkg::XSIZ_8, smc_lite_pkg::BSIZ_8}:
            be_dec = 4'b1110;   // Any byte on lane 0
         {smc_lite_pkg::XSIZ_8, smc_lite_pkg::BSIZ_16}:
            be_dec = v_addr[0] ? 4'b1101 : 4'b1110;
         {smc_lite_pkg::XSIZ_8, smc_lite_pkg::BSIZ_32}:
            be_dec = ~(4'b0001 << v_addr);   // Own lane
         {smc_lite_pkg::XSIZ_16, smc_lite_pkg::BSIZ_8}:
            be_dec = 4'b1110;
         {smc_lite_pkg::XSIZ_16, smc_lite_pkg::BSIZ_16}:
            be_dec = 4'b1100;
         {smc_lite_pkg::XSIZ_16, smc_lite_pkg::BSIZ_32}:
            be_dec = v_addr[1] ? 4'b0011 : 4'b1100;   // Upper or lower half
         {smc_lite_pkg::XSIZ_32, smc_lite_pkg::BSIZ_8}:
            be_dec = 4'b1110;
         {smc_lite_pkg::XSIZ_32, smc_lite_pkg::BSIZ_16}:
            be_dec = 4'b1100;
         {smc_lite_pkg::XSIZ_32, smc_lite_pkg::BSIZ_32}:
            be_dec = 4'b0000;   // Whole word
         default:
            be_dec = 4'b1111;
      endcase
   end

   // Registered strobes --------------------
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
      begin
         n_cs <= 1'b1;
         n_be <= 4'hF;
      end
      else if (acc_rw)
      begin
         n_cs <= 1'b0;
         n_be <= be_dec;
      end
      else
      begin
         n_cs <= 1'b1;   // Idle between accesses
         n_be <= 4'hF;
      end
   end

endmodule

//--- verilog/smc_data_lane.sv
/*
 * EMI data lane handling
 * Steers write bytes onto the low bus lanes and drives n_we / n_oe
 * Gathers returned read lanes into one little-endian word
 */

`timescale 1ns/1ps

module smc_data_lane (
   input  logic                     sys_clk12,
   input  logic                     n_sys_reset12,
   input  smc_lite_pkg::smc_req_t   cur_req,       // Captured request
   input  smc_lite_pkg::size_t      bus_size,      // External bus width
   input  smc_lite_pkg::smc_state_e smc_nextstate, // Next access state
   input  smc_lite_pkg::acc_cnt_t   r_num_access,  // Accesses still to go
   output logic                     n_we,          // EMI write enable
   output logic                     n_oe,          // EMI output enable
   output smc_lite_pkg::data_t      wdata,         // EMI write data
   input  smc_lite_pkg::data_t      emi_rdata,     // EMI read data
   output smc_lite_pkg::data_t      rd_word        // Assembled read word
);

   logic                acc_rw;     // Access strobes next cycle
   logic                r_rw;       // acc_rw one cycle late
   logic                first;      // First access of a transfer
   logic [1:0]          acc_lo;     // Low address bits of this access
   logic [1:0]          lane_mask;  // Address bits above the bus width
   logic [1:0]          acc_pos;    // Byte position of the low bus lane
   logic [1:0]          r_pos;      // Position of the access on the bus now
   smc_lite_pkg::data_t r_word;     // Lanes gathered so far

   assign acc_rw  = (smc_nextstate == smc_lite_pkg::SMC_RW);
   assign first   = acc_rw && !r_rw;
   assign acc_lo  = smc_lite_pkg::acc_low(cur_req.xfer_size, bus_size, cur_req.addr[1:0],
                                          first, r_num_access);

   always_comb
   begin
      case (bus_size)
         smc_lite_pkg::BSIZ_8:  lane_mask = 2'b11;
         smc_lite_pkg::BSIZ_16: lane_mask = 2'b10;
         default:               lane_mask = 2'b00;   // 32 bit needs no shift
      endcase
   end

   assign acc_pos = acc_lo & lane_mask;

   // Strobes --------------------
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
      begin
         r_rw <= 1'b0;
         n_we <= 1'b1;
         n_oe <= 1'b1;
      end
      else
      begin
         r_rw <= acc_rw;
         n_we <= !(acc_rw && cur_req.write);
         n_oe <= !(acc_rw && !cur_req.write);
      end
   end

   // Read word with the lane on the bus now merged in --------------------
   always_comb
   begin
      rd_word = r_word;
      if (!n_oe)
      begin
         case (bus_size)
            smc_lite_pkg::BSIZ_8:  rd_word[{r_pos, 3'b000} +: 8]  = emi_rdata[7:0];
            smc_lite_pkg::BSIZ_16: rd_word[{r_pos, 3'b000} +: 16] = emi_rdata[15:0];
            default:               rd_word = emi_rdata;
         endcase
      end
   end

   // Write steering and read assembly --------------------
   always_ff @(posedge sys_clk12)
   begin
      if (acc_rw)
      begin
         wdata <= cur_req.wdata >> {acc_pos, 3'b000};   // Wanted part to lane 0
         r_pos <= acc_pos;
      end
      if (first)
         r_word <= '0;   // New transfer
      else if (!n_oe)
         r_word <= rd_word;   // Keep lanes read so far
   end

endmodule

//--- verilog/smc_lite.sv
/*
 * Static memory controller top level
 * Host req/ack port on one side, external memory bus on the other
 */

`timescale 1ns/1ps

module smc_lite #(
   parameter int ADDR_WIDTH = 24   // External address port width
) (
   input  logic                   sys_clk12,
   input  logic                   n_sys_reset12,
   input  logic                   req,
   output logic                   ack,
   input  smc_lite_pkg::smc_req_t req_in,
   output smc_lite_pkg::data_t    rdata,
   input  smc_lite_pkg::size_t    bus_size,   // Strap
   output logic [ADDR_WIDTH-1:0]  emi_addr,
   output smc_lite_pkg::smc_emi_t emi,
   input  smc_lite_pkg::data_t    emi_rdata
);

   smc_lite_pkg::smc_req_t   cur_req;
   smc_lite_pkg::smc_state_e smc_nextstate;
   smc_lite_pkg::acc_cnt_t   r_num_access;
   smc_lite_pkg::data_t      rd_word;
   smc_lite_pkg::data_t      emi_wdata;
   smc_lite_pkg::be_t        emi_n_be;
   logic                     valid_access;
   logic                     smc_done;
   logic                     emi_n_cs;
   logic                     emi_n_we;
   logic                     emi_n_oe;

   assign emi = '{n_cs: emi_n_cs, n_be: emi_n_be, n_we: emi_n_we, n_oe: emi_n_oe,
                  wdata: emi_wdata};

   smc_host_if u_host_if (
      .sys_clk12(sys_clk12), .n_sys_reset12(n_sys_reset12), .req(req), .ack(ack),
      .req_in(req_in), .rdata(rdata), .cur_req(cur_req), .valid_access(valid_access),
      .smc_done(smc_done), .rd_word(rd_word)
   );

   smc_access_ctrl u_access_ctrl (
      .sys_clk12(sys_clk12), .n_sys_reset12(n_sys_reset12), .valid_access(valid_access),
      .xfer_size(cur_req.xfer_size), .bus_size(bus_size), .smc_nextstate(smc_nextstate),
      .r_num_access(r_num_access), .smc_done(smc_done)
   );

   smc_addr_gen #(.ADDR_WIDTH(ADDR_WIDTH)) u_addr_gen (
      .sys_clk12(sys_clk12), .n_sys_reset12(n_sys_reset12), .valid_access(valid_access),
      .cur_req(cur_req), .bus_size(bus_size), .smc_nextstate(smc_nextstate),
      .r_num_access(r_num_access), .emi_addr(emi_addr), .n_cs(emi_n_cs), .n_be(emi_n_be)
   );

   smc_data_lane u_data_lane (
      .sys_clk12(sys_clk12), .n_sys_reset12(n_sys_reset12), .cur_req(cur_req),
      .bus_size(bus_size), .smc_nextstate(smc_nextstate), .r_num_access(r_num_access),
      .n_we(emi_n_we), .n_oe(emi_n_oe), .wdata(emi_wdata), .emi_rdata(emi_rdata),
      .rd_word(rd_word)
   );

endmodule

//--- dv/smc_lite_properties.sv
/*
 * Handshake and strobe assertions for the memory controller
 * Bound into the top level, where host port and access state meet
 */

`timescale 1ns/1ps

module smc_lite_properties (
   input logic                     sys_clk12,
   input logic                     n_sys_reset12,
   input logic                     req,
   input logic                     ack,
   input smc_lite_pkg::smc_emi_t   emi,
   input smc_lite_pkg::smc_state_e smc_nextstate
);

   // Ack only answers a pending request
   ack_needs_req: assert property (@(posedge sys_clk12) disable iff (!n_sys_reset12)
      $rose(ack) |-> $past(req))
      else $error("ack rose without a request");

   // Never drive and read the bus at once
   we_oe_exclusive: assert property (@(posedge sys_clk12) disable iff (!n_sys_reset12)
      !(!emi.n_we && !emi.n_oe))
      else $error("n_we and n_oe low together");

   // Strobes lag the state by one register stage
   cs_only_in_rw: assert property (@(posedge sys_clk12) disable iff (!n_sys_reset12)
      !emi.n_cs |-> ($past(smc_nextstate) == smc_lite_pkg::SMC_RW))
      else $error("n_cs low outside an access");

endmodule

bind smc_lite smc_lite_properties u_props (
   .sys_clk12(sys_clk12), .n_sys_reset12(n_sys_reset12), .req(req), .ack(ack),
   .emi(emi), .smc_nextstate(smc_nextstate)
);

//--- dv/smc_lite_tb.sv
/*
 * Testbench for the static memory controller
 * Byte memory model on the EMI, directed and random host transfers
 */

`timescale 1ns/1ps

module smc_lite_tb;

   localparam int NUM_RANDOM  = 60;
   localparam int NUM_XFERS   = 21 + NUM_RANDOM;   // Directed plus random
   localparam int CYCLE_LIMIT = 40 * NUM_XFERS;

   logic                   sys_clk12;
   logic                   n_sys_reset12;
   logic                   req;
   logic                   ack;
   smc_lite_pkg::smc_req_t req_in;
   smc_lite_pkg::data_t    rdata;
   smc_lite_pkg::size_t    bus_size;   // Strap
   logic [23:0]            emi_addr;
   smc_lite_pkg::smc_emi_t emi;
   smc_lite_pkg::data_t    emi_rdata = '0;

   logic [7:0]  emi_mem [int unsigned];   // Device contents
   logic [7:0]  ref_mem [int unsigned];   // Expected contents
   logic [27:0] acc_log [$];              // {emi_addr, n_be} per access
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   integer      seed = 32'hd0bb_baea;

   smc_lite #(.ADDR_WIDTH(24)) dut0 (.*);

   initial
   begin
      sys_clk12 = 1'b0;
      forever #4 sys_clk12 = ~sys_clk12;   // 8 ns period
   end

   // Helpers --------------------
   function automatic logic [7:0] fill_byte(int unsigned a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;   // Unwritten locations
   endfunction

   function automatic logic [7:0] mem_byte(int unsigned a);
      return emi_mem.exists(a) ? emi_mem[a] : fill_byte(a);
   endfunction

   function automatic int bus_bytes(smc_lite_pkg::size_t s);
      return 1 << s;
   endfunction

   function automatic int expected_accesses(smc_lite_pkg::size_t xs, smc_lite_pkg::size_t bs);
      if (xs <= bs)
         return 1;
      return ((xs - bs) == 1) ? 2 : 4;   // Word on 8 takes four
   endfunction

   // i-th byte of a transfer in the 24 bit external space
   function automatic int unsigned byte_addr(smc_lite_pkg::addr_t a, smc_lite_pkg::size_t xs,
                                             int i);
      return ((a & ~((32'd1 << xs) - 32'd1)) + 32'(i)) & 32'h00ff_ffff;
   endfunction

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // EMI memory model --------------------
   always @(negedge sys_clk12)
   begin
      int unsigned base;
      base = 32'(emi_addr) & ~(bus_bytes(bus_size) - 1);   // Lane 0 address
      emi_rdata = '0;
      if (!emi.n_cs)
         acc_log.push_back({emi_addr, emi.n_be});
      for (int n = 0; n < bus_bytes(bus_size); n++)
      begin
         if (!emi.n_cs && !emi.n_we && !emi.n_be[n])
            emi_mem[base + n] = emi.wdata[8*n +: 8];
         if (!emi.n_cs && !emi.n_oe)
            emi_rdata[8*n +: 8] = mem_byte(base + n);
      end
   end

   always @(posedge sys_clk12)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles, a transfer never completed", cycles);
         $display("Errors found");
         $finish;
      end
   end

   // One host transfer started on a falling edge
   task automatic transfer(input logic wr, input smc_lite_pkg::addr_t a,
                           input smc_lite_pkg::size_t xs, input smc_lite_pkg::data_t wd,
                           input smc_lite_pkg::size_t bs);
      int unsigned         ba;
      smc_lite_pkg::data_t exp;
      smc_lite_pkg::data_t mask;
      exp  = '0;
      mask = '0;
      bus_size = bs;   // Only changed while idle
      acc_log.delete();
      req_in = '{addr: a, xfer_size: xs, write: wr, wdata: wd};
      req = 1'b1;
      @(negedge sys_clk12);
      while (!ack)
         @(negedge sys_clk12);
      for (int i = 0; i < (1 << xs); i++)
      begin
         ba = byte_addr(a, xs, i);
         mask[8*ba[1:0] +: 8] = 8'hff;   // Lane of this byte
         if (wr)
            ref_mem[ba] = wd[8*ba[1:0] +: 8];
         else
            exp[8*ba[1:0] +: 8] = ref_mem.exists(ba) ? ref_mem[ba] : fill_byte(ba);
      end
      if (!wr)
         compare(rdata & mask, exp, "read data");
      compare(acc_log.size(), expected_accesses(xs, bs), "EMI access count");
      repeat (2)
      begin
         @(negedge sys_clk12);
         compare(32'(ack), 1, "ack held while req high");
      end
      req = 1'b0;
      @(negedge sys_clk12);
      compare(32'(ack), 0, "ack release after req drop");
   endtask

   // Directed tests --------------------
   task automatic idle_after_reset();
      compare(32'({ack, emi.n_cs, emi.n_we, emi.n_oe, emi.n_be}), 32'h7f, "idle strobes");
   endtask

   task automatic word_on_32();
      smc_lite_pkg::data_t d;
      d = $random(seed);
      transfer(1'b1, 32'h0000_0040, smc_lite_pkg::XSIZ_32, d, smc_lite_pkg::BSIZ_32);
      compare(32'(acc_log[0][3:0]), 32'h0, "word enables on 32 bit");
      transfer(1'b0, 32'h0000_0040, smc_lite_pkg::XSIZ_32, '0, smc_lite_pkg::BSIZ_32);
   endtask

   task automatic word_on_8();
      smc_lite_pkg::data_t d;
      d = $random(seed);
      // Upper byte lies above the 24 bit port
      transfer(1'b1, 32'h5a00_0080, smc_lite_pkg::XSIZ_32, d, smc_lite_pkg::BSIZ_8);
      for (int k = 0; k < 4; k++)
      begin
         compare(32'(acc_log[k]), 32'({22'h20, 2'(3 - k), 4'b1110}), "byte lane access");
         compare(32'(mem_byte(32'h80 + k)), 32'(d[8*k +: 8]), "stored byte order");
      end
      transfer(1'b0, 32'h0000_0080, smc_lite_pkg::XSIZ_32, '0, smc_lite_pkg::BSIZ_8);
   endtask

   task automatic parts_on_16();
      for (int a = 0; a < 4; a += 2)   // Halfwords at a1 = 0 and 1
      begin
         transfer(1'b1, 32'h100 + a, smc_lite_pkg::XSIZ_16, $random(seed),
                  smc_lite_pkg::BSIZ_16);
         compare(32'(acc_log[0]), 32'({22'h40, 2'(a), 4'b1100}), "halfword access");
      end
      for (int a = 0; a < 4; a++)
      begin
         transfer(1'b1, 32'h200 + a, smc_lite_pkg::XSIZ_8, $random(seed),
                  smc_lite_pkg::BSIZ_16);
         compare(32'(acc_log[0]), 32'({22'h80, 2'(a), 4'b1111 ^ (4'b0001 << a[0])}),
                 "byte access on 16 bit");
      end
      transfer(1'b0, 32'h100, smc_lite_pkg::XSIZ_32, '0, smc_lite_pkg::BSIZ_16);
      transfer(1'b0, 32'h200, smc_lite_pkg::XSIZ_32, '0, smc_lite_pkg::BSIZ_16);
   endtask

   task automatic counts_all_pairs();
      for (int b = 0; b < 3; b++)
         for (int x = 0; x < 3; x++)
            transfer(1'b0, $random(seed), 2'(x), '0, 2'(b));
   endtask

   task automatic random_traffic(input int count);
      smc_lite_pkg::addr_t a;
      for (int i = 0; i < count; i++)
      begin
         a = ($random(seed) & 32'hff00_003f) | 32'h0000_4000;   // Small window so reads hit
         transfer(1'($random(seed)), a, 2'($unsigned($random(seed)) % 3), $random(seed),
                  2'($unsigned($random(seed)) % 3));
      end
   endtask

   // Main sequence --------------------
   initial
   begin
      n_sys_reset12 = 1'b0;
      req           = 1'b0;
      req_in        = '0;
      bus_size      = smc_lite_pkg::BSIZ_32;
      repeat (8) @(posedge sys_clk12);
      @(negedge sys_clk12);
      n_sys_reset12 = 1'b1;
      @(negedge sys_clk12);
      idle_after_reset();
      word_on_32();
      word_on_8();
      parts_on_16();
      counts_all_pairs();
      random_traffic(NUM_RANDOM);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- smc_lite.f
verilog/smc_lite_pkg.sv
verilog/smc_host_if.sv
verilog/smc_access_ctrl.sv
verilog/smc_addr_gen.sv
verilog/smc_data_lane.sv
verilog/smc_lite.sv
dv/smc_lite_properties.sv
dv/smc_lite_tb.sv

//--- Makefile
# Verilator build and run of the static memory controller testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module smc_lite_tb \
		-f smc_lite.f -Mdir obj_dir
	./obj_dir/Vsmc_lite_tb | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
